// File: sim/mhq_tb.sv
/* Directed testbench for the MHQ. Memory line bytes are (address ^ 8'hA5) and
   every wait is bounded by TIMEOUT cycles */
`include "mhq_params.svh"

module mhq_tb;

    localparam int LINE_BYTES = `MHQ_LINE_SIZE;
    localparam int WORD_BYTES = `MHQ_DATA_WIDTH / 8;
    localparam int TIMEOUT    = 400;

    logic                          clk;
    logic                          n_rst;
    logic                          i_req_en;
    logic                          i_req_we;
    logic [`MHQ_ADDR_WIDTH-1:0]    i_req_addr;
    logic [`MHQ_DATA_WIDTH-1:0]    i_req_wr_data;
    mhq_pkg::mhq_bsel_t            i_req_byte_select;
    logic                          o_full;
    logic                          o_fill_en;
    mhq_pkg::mhq_tag_t             o_fill_tag;
    logic                          o_fill_dirty;
    logic [`MHQ_ADDR_WIDTH-1:0]    o_fill_addr;
    mhq_pkg::mhq_line_t            o_fill_data;
    logic                          o_mem_req;
    logic [`MHQ_ADDR_WIDTH-1:0]    o_mem_addr;
    logic                          i_mem_ack;
    mhq_pkg::mhq_line_t            i_mem_data;

    // Memory model controls
    logic                          mem_stall;
    int                            mem_delay;
    int                            mem_wait;

    // Ack seen at the previous negedge
    logic                          ack_seen;

    logic [31:0]                   lfsr;
    int                            error_count;
    int                            fill_count;
    int                            alloc_count;

    // Requests taken by the DUT and not yet applied to the reference model
    logic                          rq_we   [$];
    logic [`MHQ_ADDR_WIDTH-1:0]    rq_addr [$];
    logic [`MHQ_DATA_WIDTH-1:0]    rq_data [$];
    mhq_pkg::mhq_bsel_t            rq_bsel [$];

    // Reference model of the pending lines in allocation order
    logic [`MHQ_ADDR_WIDTH-1:0]    exp_addr  [$];
    mhq_pkg::mhq_line_t            exp_data  [$];
    logic                          exp_dirty [$];
    mhq_pkg::mhq_tag_t             exp_tag   [$];

    mhq_top mhq_top_inst (
        .clk               (clk),
        .n_rst             (n_rst),
        .i_req_en          (i_req_en),
        .i_req_we          (i_req_we),
        .i_req_addr        (i_req_addr),
        .i_req_wr_data     (i_req_wr_data),
        .i_req_byte_select (i_req_byte_select),
        .o_full            (o_full),
        .o_fill_en         (o_fill_en),
        .o_fill_tag        (o_fill_tag),
        .o_fill_dirty      (o_fill_dirty),
        .o_fill_addr       (o_fill_addr),
        .o_fill_data       (o_fill_data),
        .o_mem_req         (o_mem_req),
        .o_mem_addr        (o_mem_addr),
        .i_mem_ack         (i_mem_ack),
        .i_mem_data        (i_mem_data)
    );

    always #50 clk = ~clk;

    function automatic mhq_pkg::mhq_line_t mem_line(input logic [`MHQ_ADDR_WIDTH-1:0] base);
        mhq_pkg::mhq_line_t         line;
        logic [`MHQ_ADDR_WIDTH-1:0] a;
        for (int i = 0; i < LINE_BYTES; i++) begin
            a = base + i;
            line[i*8 +: 8] = a[7:0] ^ 8'hA5;
        end
        return line;
    endfunction

    function automatic logic [`MHQ_ADDR_WIDTH-1:0] line_base(input logic [`MHQ_ADDR_WIDTH-1:0] a);
        return (a / LINE_BYTES) * LINE_BYTES;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Memory answers a pending read after mem_delay cycles unless stalled
    always @(posedge clk) begin
        if (!n_rst) begin
            i_mem_ack <= 1'b0;
            mem_wait  <= 0;
        end else if (i_mem_ack) begin
            i_mem_ack <= 1'b0;
            mem_wait  <= 0;
        end else if (o_mem_req && !mem_stall) begin
            if (mem_wait >= mem_delay) begin
                i_mem_ack  <= 1'b1;
                i_mem_data <= mem_line(o_mem_addr);
            end else begin
                mem_wait <= mem_wait + 1;
            end
        end
    end

    // Record each request at the edge where the DUT takes it
    always @(posedge clk) begin
        if (n_rst && i_req_en) begin
            rq_we.push_back(i_req_we);
            rq_addr.push_back(i_req_addr);
            rq_data.push_back(i_req_wr_data);
            rq_bsel.push_back(i_req_byte_select);
        end
    end

    task automatic check_fill();
        fill_count++;
        if (exp_addr.size() == 0) begin
            $display("Unexpected fill at %0t for address %h while no line was pending",
                     $time, o_fill_addr);
            error_count++;
        end else begin
            if (o_fill_addr !== exp_addr[0]) begin
                $display("[ERROR] %0t: o_fill_addr expected %h got %h",
                         $time, exp_addr[0], o_fill_addr);
                error_count++;
            end
            if (o_fill_tag !== exp_tag[0]) begin
                $display("[ERROR] %0t: o_fill_tag expected %0d got %0d",
                         $time, exp_tag[0], o_fill_tag);
                error_count++;
            end
            if (o_fill_dirty !== exp_dirty[0]) begin
                $display("[ERROR] %0t: o_fill_dirty expected %b got %b",
                         $time, exp_dirty[0], o_fill_dirty);
                error_count++;
            end
            if (o_fill_data !== exp_data[0]) begin
                $display("[ERROR] %0t: o_fill_data expected %h got %h",
                         $time, exp_data[0], o_fill_data);
                error_count++;
            end
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            void'(exp_dirty.pop_front());
            void'(exp_tag.pop_front());
        end
    endtask

    // A read targets the oldest pending line and ends one edge after its ack
    task automatic check_mem_bus();
        if (ack_seen && o_mem_req !== 1'b0) begin
            $display("[ERROR] %0t: o_mem_req expected 0 got %b", $time, o_mem_req);
            error_count++;
        end
        if (i_mem_ack) begin
            if (exp_addr.size() == 0) begin
                $display("Memory read at %0t for address %h while no line was pending",
                         $time, o_mem_addr);
                error_count++;
            end else if (o_mem_addr !== exp_addr[0]) begin
                $display("[ERROR] %0t: o_mem_addr expected %h got %h",
                         $time, exp_addr[0], o_mem_addr);
                error_count++;
            end
        end
        ack_seen = i_mem_ack;
    endtask

    // A request merges into any line still pending, otherwise it allocates the next tag
    task automatic apply_requests();
        int                         idx;
        int                         word;
        logic [`MHQ_ADDR_WIDTH-1:0] base;
        mhq_pkg::mhq_line_t         line;
        while (rq_we.size() > 0) begin
            base = line_base(rq_addr[0]);
            idx  = -1;
            for (int i = 0; i < exp_addr.size(); i++) begin
                if (exp_addr[i] == base) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                exp_addr.push_back(base);
                exp_data.push_back(mem_line(base));
                exp_dirty.push_back(1'b0);
                exp_tag.push_back(mhq_pkg::mhq_tag_t'(alloc_count % `MHQ_DEPTH));
                alloc_count++;
                idx = exp_addr.size() - 1;
            end
            if (rq_we[0]) begin
                line = exp_data[idx];
                word = (rq_addr[0] - base) / WORD_BYTES;
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (rq_bsel[0][b]) begin
                        line[(word*WORD_BYTES + b)*8 +: 8] = rq_data[0][b*8 +: 8];
                    end
                end
                exp_data[idx]  = line;
                exp_dirty[idx] = 1'b1;
            end
            void'(rq_we.pop_front());
            void'(rq_addr.pop_front());
            void'(rq_data.pop_front());
            void'(rq_bsel.pop_front());
        end
    endtask

    // Fill set at an edge holds requests taken before that edge, so check first
    always @(negedge clk) begin
        if (n_rst) begin
            if (o_fill_en) begin
                check_fill();
            end
            check_mem_bus();
            apply_requests();
        end
    end

    task automatic set_mem(input logic stall, input int delay);
        @(posedge clk);
        mem_stall <= stall;
        mem_delay <= delay;
    endtask

    // Drives a request at the next edge and leaves i_req_en high for a following one
    task automatic send_next(input logic we, input logic [`MHQ_ADDR_WIDTH-1:0] addr,
                             input logic [`MHQ_DATA_WIDTH-1:0] data,
                             input mhq_pkg::mhq_bsel_t bsel);
        @(posedge clk);
        i_req_en          <= 1'b1;
        i_req_we          <= we;
        i_req_addr        <= addr;
        i_req_wr_data     <= data;
        i_req_byte_select <= bsel;
    endtask

    task automatic end_burst();
        @(posedge clk);
        i_req_en <= 1'b0;
    endtask

    task automatic send_req(input logic we, input logic [`MHQ_ADDR_WIDTH-1:0] addr,
                            input logic [`MHQ_DATA_WIDTH-1:0] data,
                            input mhq_pkg::mhq_bsel_t bsel);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (o_full && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (o_full) begin
            $display("Timeout at %0t: o_full never dropped, request to %h not sent", $time, addr);
            error_count++;
        end else begin
            send_next(we, addr, data, bsel);
            end_burst();
        end
    endtask

    // Wait until every pending line has filled, then a quiet period to catch extra fills
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while ((rq_we.size() != 0 || exp_addr.size() != 0) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rq_we.size() != 0 || exp_addr.size() != 0) begin
            $display("Timeout at %0t: %0d lines never filled", $time, exp_addr.size());
            error_count++;
        end
        repeat (10) @(posedge clk);
    endtask

    task automatic check_fills(input int fills_before, input int expected);
        if (fill_count - fills_before != expected) begin
            $display("[ERROR] %0t: o_fill_en count expected %0d got %0d",
                     $time, expected, fill_count - fills_before);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %-16s %s, %0d errors", name,
                 (error_count == errs_before) ? "ok" : "mismatch", error_count - errs_before);
    endtask

    task automatic test_load_miss();
        int errs;
        int fills;
        errs  = error_count;
        fills = fill_count;
        set_mem(1'b0, 2);
        send_req(1'b0, 32'h0000_1044, '0, '0);
        wait_idle();
        check_fills(fills, 1);
        report_test("load miss", errs);
    endtask

    task automatic test_store_miss();
        int          errs;
        int          fills;
        logic [31:0] data;
        errs  = error_count;
        fills = fill_count;
        draw_bits(32, data);
        set_mem(1'b0, 4);
        send_req(1'b1, 32'h0000_2088, data, 4'b0110);
        wait_idle();
        check_fills(fills, 1);
        report_test("store miss", errs);
    endtask

    task automatic test_merge();
        int          errs;
        int          fills;
        logic [31:0] d0;
        logic [31:0] d1;
        errs  = error_count;
        fills = fill_count;
        draw_bits(32, d0);
        draw_bits(32, d1);
        set_mem(1'b1, 1);
        // Back to back, so the second store meets the first while it is still allocating
        send_next(1'b1, 32'h0000_3004, d0, 4'b1111);
        send_next(1'b1, 32'h0000_3010, d1, 4'b1001);
        send_next(1'b0, 32'h0000_301C, '0, '0);
        end_burst();
        set_mem(1'b0, 1);
        wait_idle();
        check_fills(fills, 1);
        report_test("merge", errs);
    endtask

    task automatic test_full_order();
        int errs;
        int fills;
        errs  = error_count;
        fills = fill_count;
        set_mem(1'b1, 1);
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            send_req(1'b0, 32'h0000_5000 + i * LINE_BYTES, '0, '0);
        end
        @(negedge clk);
        if (o_full !== 1'b1) begin
            $display("[ERROR] %0t: o_full expected 1 got %b", $time, o_full);
            error_count++;
        end
        set_mem(1'b0, 1);
        wait_idle();
        @(negedge clk);
        if (o_full !== 1'b0) begin
            $display("[ERROR] %0t: o_full expected 0 got %b", $time, o_full);
            error_count++;
        end
        check_fills(fills, `MHQ_DEPTH);
        report_test("full and order", errs);
    endtask

    task automatic test_random();
        int          errs;
        int          fills;
        int          allocs;
        logic [31:0] we;
        logic [31:0] line;
        logic [31:0] word;
        logic [31:0] data;
        logic [31:0] bsel;
        errs   = error_count;
        fills  = fill_count;
        allocs = alloc_count;
        set_mem(1'b0, 3);
        for (int n = 0; n < 20; n++) begin
            draw_bits(1, we);
            draw_bits(3, line);
            draw_bits(3, word);
            draw_bits(32, data);
            draw_bits(WORD_BYTES, bsel);
            send_req(we[0], 32'h0000_6000 + (line % 6) * LINE_BYTES +
                     (word % (LINE_BYTES / WORD_BYTES)) * WORD_BYTES,
                     data, mhq_pkg::mhq_bsel_t'(bsel));
        end
        wait_idle();
        check_fills(fills, alloc_count - allocs);
        report_test("random", errs);
    endtask

    initial begin
        clk               = 1'b0;
        n_rst             = 1'b0;
        i_req_en          = 1'b0;
        i_req_we          = 1'b0;
        i_req_addr        = '0;
        i_req_wr_data     = '0;
        i_req_byte_select = '0;
        i_mem_ack         = 1'b0;
        i_mem_data        = '0;
        mem_stall         = 1'b0;
        mem_delay         = 2;
        mem_wait          = 0;
        ack_seen          = 1'b0;
        lfsr              = 32'h87037014;
        error_count       = 0;
        fill_count        = 0;
        alloc_count       = 0;
        repeat (3) @(posedge clk);
        n_rst <= 1'b1;
        test_load_miss();
        test_store_miss();
        test_merge();
        test_full_order();
        test_random();
        $display("Summary: 5 tests, %0d fills, %0d allocations, %0d errors",
                 fill_count, alloc_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/mhq_pkg.sv
src/mhq_lu.sv
src/mhq_ex.sv
src/mhq_ccu.sv
src/mhq_top.sv
sim/mhq_tb.sv

// File: src/mhq_ccu.sv
/* Cache-control unit with one requester. One line read per head entry, any memory
   latency; a cooldown cycle follows each completion */
`include "mhq_params.svh"

module mhq_ccu (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            i_ccu_en,
    input  logic [`MHQ_ADDR_WIDTH-1:0]      i_ccu_addr,
    input  logic                            i_mem_ack,
    input  mhq_pkg::mhq_line_t              i_mem_data,
    output logic                            o_ccu_done,
    output mhq_pkg::mhq_line_t              o_ccu_data,
    output logic                            o_mem_req,
    output logic [`MHQ_ADDR_WIDTH-1:0]      o_mem_addr
);

    typedef enum logic [1:0] {
        CCU_IDLE,
        CCU_WAIT,
        CCU_COOL
    } ccu_state_t;

    ccu_state_t state;
    logic       issue;
    logic       complete;

    assign issue    = (state == CCU_IDLE) & i_ccu_en;
    assign complete = (state == CCU_WAIT) & i_mem_ack;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state      <= CCU_IDLE;
            o_mem_req  <= 1'b0;
            o_ccu_done <= 1'b0;
        end else begin
            o_ccu_done <= complete;
            case (state)
                CCU_IDLE: begin
                    if (issue) begin
                        o_mem_req <= 1'b1;
                        state     <= CCU_WAIT;
                    end
                end
                CCU_WAIT: begin
                    if (complete) begin
                        o_mem_req <= 1'b0;
                        state     <= CCU_COOL;
                    end
                end
                // Head pointer advances during this cycle
                CCU_COOL: state <= CCU_IDLE;
                default:  state <= CCU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            o_mem_addr <= i_ccu_addr;
        end
        if (complete) begin
            o_ccu_data <= i_mem_data;
        end
    end

endmodule

// File: src/mhq_ex.sv
/* Execute stage. Holds the queue entries and emits one merged fill per line in
   allocation order. Store offsets are assumed word aligned */
`include "mhq_params.svh"

module mhq_ex (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            i_mhq_lu_en,
    input  logic                            i_mhq_lu_we,
    input  mhq_pkg::mhq_offset_t            i_mhq_lu_offset,
    input  logic [`MHQ_DATA_WIDTH-1:0]      i_mhq_lu_wr_data,
    input  mhq_pkg::mhq_bsel_t              i_mhq_lu_byte_select,
    input  logic                            i_mhq_lu_match,
    input  mhq_pkg::mhq_tag_t               i_mhq_lu_tag,
    input  mhq_pkg::mhq_line_addr_t         i_mhq_lu_addr,
    input  logic                            i_ccu_done,
    input  mhq_pkg::mhq_line_t              i_ccu_data,
    output mhq_pkg::mhq_ptr_t               o_mhq_head_next,
    output mhq_pkg::mhq_ptr_t               o_mhq_tail_next,
    output logic [`MHQ_DEPTH-1:0]           o_mhq_entry_valid,
    output mhq_pkg::mhq_line_addr_t         o_mhq_entry_addr [`MHQ_DEPTH],
    output logic                            o_ccu_en,
    output logic [`MHQ_ADDR_WIDTH-1:0]      o_ccu_addr,
    output logic                            o_fill_en,
    output mhq_pkg::mhq_tag_t               o_fill_tag,
    output logic                            o_fill_dirty,
    output logic [`MHQ_ADDR_WIDTH-1:0]      o_fill_addr,
    output mhq_pkg::mhq_line_t              o_fill_data
);

    logic [`MHQ_DEPTH-1:0]                  entry_valid_q;
    logic                                   entry_dirty_q [`MHQ_DEPTH];
    mhq_pkg::mhq_line_addr_t                entry_addr_q  [`MHQ_DEPTH];
    mhq_pkg::mhq_line_t                     entry_data_q  [`MHQ_DEPTH];
    mhq_pkg::mhq_bmask_t                    entry_bmask_q [`MHQ_DEPTH];

    mhq_pkg::mhq_ptr_t                      head;
    mhq_pkg::mhq_ptr_t                      tail;
    mhq_pkg::mhq_ptr_t                      head_next;
    mhq_pkg::mhq_ptr_t                      tail_next;
    mhq_pkg::mhq_tag_t                      head_idx;
    mhq_pkg::mhq_offset_t                   lu_word;
    logic [`MHQ_DEPTH-1:0]                  valid_next;
    logic                                   ex_en;
    logic                                   ex_alloc;
    logic                                   ex_dirty;
    logic                                   fill_merge;
    mhq_pkg::mhq_line_t                     ex_data;
    mhq_pkg::mhq_bmask_t                    ex_bmask;
    logic [`MHQ_ADDR_WIDTH-1:0]             fill_addr;
    mhq_pkg::mhq_line_t                     fill_data;

    // A load that hits a pending entry leaves the queue untouched
    assign ex_alloc   = i_mhq_lu_en & ~i_mhq_lu_match;
    assign ex_en      = i_mhq_lu_en & (~i_mhq_lu_match | i_mhq_lu_we);

    assign head_idx   = head[mhq_pkg::TAG_WIDTH-1:0];
    assign head_next  = i_ccu_done ? head + 1'b1 : head;
    assign tail_next  = ex_alloc ? tail + 1'b1 : tail;
    assign lu_word    = i_mhq_lu_offset >> mhq_pkg::WORD_SHIFT;

    // Fed back to the lookup stage without a register
    assign o_mhq_head_next   = head_next;
    assign o_mhq_tail_next   = tail_next;
    assign o_mhq_entry_valid = entry_valid_q;
    assign o_mhq_entry_addr  = entry_addr_q;

    // Head entry goes to the CCU
    assign fill_addr  = {entry_addr_q[head_idx], {mhq_pkg::OFFSET_WIDTH{1'b0}}};
    assign o_ccu_addr = fill_addr;
    assign o_ccu_en   = entry_valid_q[head_idx];

    // Store merging into the head entry while its line is returning
    assign fill_merge = ex_en & i_mhq_lu_we & ~ex_alloc & (i_mhq_lu_tag == head_idx);

    always_comb begin
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            valid_next[i] = ~(i_ccu_done & (mhq_pkg::mhq_tag_t'(i) == head_idx)) &
                            ((ex_en & (mhq_pkg::mhq_tag_t'(i) == i_mhq_lu_tag)) |
                             entry_valid_q[i]);
        end
    end

    // Store bytes on top of the entry; a new entry starts with no bytes updated
    always_comb begin
        ex_dirty = i_mhq_lu_we | (~ex_alloc & entry_dirty_q[i_mhq_lu_tag]);
        ex_data  = entry_data_q[i_mhq_lu_tag];
        ex_bmask = entry_bmask_q[i_mhq_lu_tag] & {`MHQ_LINE_SIZE{~ex_alloc}};

        for (int i = 0; i < `MHQ_LINE_SIZE; i++) begin
            if (i_mhq_lu_we && ((i / mhq_pkg::DATA_BYTES) == int'(lu_word)) &&
                i_mhq_lu_byte_select[i % mhq_pkg::DATA_BYTES]) begin
                ex_data[i*8 +: 8] = i_mhq_lu_wr_data[(i % mhq_pkg::DATA_BYTES)*8 +: 8];
                ex_bmask[i]       = 1'b1;
            end
        end
    end

    // Fill byte priority: same-cycle store, then entry bytes, then memory
    always_comb begin
        for (int i = 0; i < `MHQ_LINE_SIZE; i++) begin
            if (fill_merge && ex_bmask[i]) begin
                fill_data[i*8 +: 8] = ex_data[i*8 +: 8];
            end else if (entry_bmask_q[head_idx][i]) begin
                fill_data[i*8 +: 8] = entry_data_q[head_idx][i*8 +: 8];
            end else begin
                fill_data[i*8 +: 8] = i_ccu_data[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            entry_valid_q <= '0;
            head          <= '0;
            tail          <= '0;
            o_fill_en     <= 1'b0;
        end else begin
            entry_valid_q <= valid_next;
            head          <= head_next;
            tail          <= tail_next;
            o_fill_en     <= i_ccu_done;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_en) begin
            entry_dirty_q[i_mhq_lu_tag] <= ex_dirty;
            entry_addr_q[i_mhq_lu_tag]  <= i_mhq_lu_addr;
            entry_data_q[i_mhq_lu_tag]  <= ex_data;
            entry_bmask_q[i_mhq_lu_tag] <= ex_bmask;
        end
    end

    always_ff @(posedge clk) begin
        o_fill_tag   <= head_idx;
        o_fill_dirty <= entry_dirty_q[head_idx] | fill_merge;
        o_fill_addr  <= fill_addr;
        o_fill_data  <= fill_data;
    end

endmodule

// File: src/mhq_lu.sv
/* Lookup stage. Every request is a miss and a store is one aligned word.
   The source must keep i_req_en low while o_full is high */
`include "mhq_params.svh"

module mhq_lu (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            i_req_en,
    input  logic                            i_req_we,
    input  logic [`MHQ_ADDR_WIDTH-1:0]      i_req_addr,
    input  logic [`MHQ_DATA_WIDTH-1:0]      i_req_wr_data,
    input  mhq_pkg::mhq_bsel_t              i_req_byte_select,
    input  mhq_pkg::mhq_ptr_t               i_mhq_head_next,
    input  mhq_pkg::mhq_ptr_t               i_mhq_tail_next,
    input  logic [`MHQ_DEPTH-1:0]           i_mhq_entry_valid,
    input  mhq_pkg::mhq_line_addr_t         i_mhq_entry_addr [`MHQ_DEPTH],
    output logic                            o_full,
    output logic                            o_mhq_lu_en,
    output logic                            o_mhq_lu_we,
    output mhq_pkg::mhq_offset_t            o_mhq_lu_offset,
    output logic [`MHQ_DATA_WIDTH-1:0]      o_mhq_lu_wr_data,
    output mhq_pkg::mhq_bsel_t              o_mhq_lu_byte_select,
    output logic                            o_mhq_lu_match,
    output mhq_pkg::mhq_tag_t               o_mhq_lu_tag,
    output mhq_pkg::mhq_line_addr_t         o_mhq_lu_addr
);

    mhq_pkg::mhq_line_addr_t                req_line_addr;
    mhq_pkg::mhq_tag_t                      head_idx;
    mhq_pkg::mhq_ptr_t                      pending;
    logic [mhq_pkg::TAG_WIDTH+1:0]          pending_after;
    logic                                   accept;
    logic                                   hit;
    mhq_pkg::mhq_tag_t                      hit_tag;

    assign req_line_addr = i_req_addr[`MHQ_ADDR_WIDTH-1:mhq_pkg::OFFSET_WIDTH];
    assign head_idx      = i_mhq_head_next[mhq_pkg::TAG_WIDTH-1:0];
    assign accept        = i_req_en & ~o_full;

    // Entries still live after this edge, including the one being allocated now
    assign pending       = i_mhq_tail_next - i_mhq_head_next;

    always_comb begin
        mhq_pkg::mhq_tag_t rel;

        hit     = 1'b0;
        hit_tag = i_mhq_tail_next[mhq_pkg::TAG_WIDTH-1:0];

        // An entry freed at this edge falls outside the head_next window
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            rel = mhq_pkg::mhq_tag_t'(i) - head_idx;
            if (i_mhq_entry_valid[i] && ({1'b0, rel} < pending) &&
                (i_mhq_entry_addr[i] == req_line_addr)) begin
                hit     = 1'b1;
                hit_tag = mhq_pkg::mhq_tag_t'(i);
            end
        end

        // Previous request is allocating this cycle and is not yet valid in the queue
        if (o_mhq_lu_en && !o_mhq_lu_match && (o_mhq_lu_addr == req_line_addr)) begin
            hit     = 1'b1;
            hit_tag = o_mhq_lu_tag;
        end
    end

    // Count the allocation this request will make one edge from now
    assign pending_after = {1'b0, pending} +
                           {{(mhq_pkg::TAG_WIDTH+1){1'b0}}, accept & ~hit};

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_mhq_lu_en <= 1'b0;
            o_full      <= 1'b0;
        end else begin
            o_mhq_lu_en <= accept;
            o_full      <= (pending_after >= `MHQ_DEPTH);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_mhq_lu_we          <= i_req_we;
            o_mhq_lu_offset      <= i_req_addr[mhq_pkg::OFFSET_WIDTH-1:0];
            o_mhq_lu_wr_data     <= i_req_wr_data;
            o_mhq_lu_byte_select <= i_req_byte_select;
            o_mhq_lu_match       <= hit;
            o_mhq_lu_tag         <= hit_tag;
            o_mhq_lu_addr        <= req_line_addr;
        end
    end

endmodule

// File: src/mhq_params.svh
/* Build options for the miss-handling queue. MHQ_DEPTH and MHQ_LINE_SIZE must be powers
   of two, and MHQ_DATA_WIDTH a multiple of 8 that divides the line */
`ifndef MHQ_PARAMS_SVH
`define MHQ_PARAMS_SVH

// Store data width in bits
`define MHQ_DATA_WIDTH 32

// Byte address width
`define MHQ_ADDR_WIDTH 32

// Number of queue entries, at least 2
`define MHQ_DEPTH 4

// Cache line size in bytes
`define MHQ_LINE_SIZE 32

`endif

// File: src/mhq_pkg.sv
/* Types shared by the MHQ blocks. Widths derive from the macros in mhq_params.svh */
`include "mhq_params.svh"

package mhq_pkg;

    // Derived widths
    localparam int DATA_BYTES      = `MHQ_DATA_WIDTH / 8;
    localparam int WORD_SHIFT      = $clog2(DATA_BYTES);
    localparam int OFFSET_WIDTH    = $clog2(`MHQ_LINE_SIZE);
    localparam int TAG_WIDTH       = $clog2(`MHQ_DEPTH);
    localparam int LINE_WIDTH      = `MHQ_LINE_SIZE * 8;
    localparam int LINE_ADDR_WIDTH = `MHQ_ADDR_WIDTH - OFFSET_WIDTH;

    // One full cache line
    typedef logic [LINE_WIDTH-1:0]      mhq_line_t;

    // Byte address with the offset bits stripped
    typedef logic [LINE_ADDR_WIDTH-1:0] mhq_line_addr_t;

    typedef logic [OFFSET_WIDTH-1:0]    mhq_offset_t;
    typedef logic [TAG_WIDTH-1:0]       mhq_tag_t;

    // Extra MSB tells a full queue from an empty one
    typedef logic [TAG_WIDTH:0]         mhq_ptr_t;

    typedef logic [DATA_BYTES-1:0]      mhq_bsel_t;
    typedef logic [`MHQ_LINE_SIZE-1:0]  mhq_bmask_t;

endpackage

// File: src/mhq_top.sv
/* MHQ top level. Every request is treated as a cache miss; no victim writeback */
`include "mhq_params.svh"

module mhq_top (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            i_req_en,
    input  logic                            i_req_we,
    input  logic [`MHQ_ADDR_WIDTH-1:0]      i_req_addr,
    input  logic [`MHQ_DATA_WIDTH-1:0]      i_req_wr_data,
    input  mhq_pkg::mhq_bsel_t              i_req_byte_select,
    output logic                            o_full,
    output logic                            o_fill_en,
    output mhq_pkg::mhq_tag_t               o_fill_tag,
    output logic                            o_fill_dirty,
    output logic [`MHQ_ADDR_WIDTH-1:0]      o_fill_addr,
    output mhq_pkg::mhq_line_t              o_fill_data,
    output logic                            o_mem_req,
    output logic [`MHQ_ADDR_WIDTH-1:0]      o_mem_addr,
    input  logic                            i_mem_ack,
    input  mhq_pkg::mhq_line_t              i_mem_data
);

    // Lookup to execute
    logic                                   lu_en;
    logic                                   lu_we;
    mhq_pkg::mhq_offset_t                   lu_offset;
    logic [`MHQ_DATA_WIDTH-1:0]             lu_wr_data;
    mhq_pkg::mhq_bsel_t                     lu_byte_select;
    logic                                   lu_match;
    mhq_pkg::mhq_tag_t                      lu_tag;
    mhq_pkg::mhq_line_addr_t                lu_addr;

    // Execute back to lookup
    mhq_pkg::mhq_ptr_t                      mhq_head_next;
    mhq_pkg::mhq_ptr_t                      mhq_tail_next;
    logic [`MHQ_DEPTH-1:0]                  entry_valid;
    mhq_pkg::mhq_line_addr_t                entry_addr [`MHQ_DEPTH];

    // Execute and CCU
    logic                                   ccu_en;
    logic [`MHQ_ADDR_WIDTH-1:0]             ccu_addr;
    logic                                   ccu_done;
    mhq_pkg::mhq_line_t                     ccu_data;

    mhq_lu mhq_lu_inst (
        .clk                  (clk),
        .n_rst                (n_rst),
        .i_req_en             (i_req_en),
        .i_req_we             (i_req_we),
        .i_req_addr           (i_req_addr),
        .i_req_wr_data        (i_req_wr_data),
        .i_req_byte_select    (i_req_byte_select),
        .i_mhq_head_next      (mhq_head_next),
        .i_mhq_tail_next      (mhq_tail_next),
        .i_mhq_entry_valid    (entry_valid),
        .i_mhq_entry_addr     (entry_addr),
        .o_full               (o_full),
        .o_mhq_lu_en          (lu_en),
        .o_mhq_lu_we          (lu_we),
        .o_mhq_lu_offset      (lu_offset),
        .o_mhq_lu_wr_data     (lu_wr_data),
        .o_mhq_lu_byte_select (lu_byte_select),
        .o_mhq_lu_match       (lu_match),
        .o_mhq_lu_tag         (lu_tag),
        .o_mhq_lu_addr        (lu_addr)
    );

    mhq_ex mhq_ex_inst (
        .clk                  (clk),
        .n_rst                (n_rst),
        .i_mhq_lu_en          (lu_en),
        .i_mhq_lu_we          (lu_we),
        .i_mhq_lu_offset      (lu_offset),
        .i_mhq_lu_wr_data     (lu_wr_data),
        .i_mhq_lu_byte_select (lu_byte_select),
        .i_mhq_lu_match       (lu_match),
        .i_mhq_lu_tag         (lu_tag),
        .i_mhq_lu_addr        (lu_addr),
        .i_ccu_done           (ccu_done),
        .i_ccu_data           (ccu_data),
        .o_mhq_head_next      (mhq_head_next),
        .o_mhq_tail_next      (mhq_tail_next),
        .o_mhq_entry_valid    (entry_valid),
        .o_mhq_entry_addr     (entry_addr),
        .o_ccu_en             (ccu_en),
        .o_ccu_addr           (ccu_addr),
        .o_fill_en            (o_fill_en),
        .o_fill_tag           (o_fill_tag),
        .o_fill_dirty         (o_fill_dirty),
        .o_fill_addr          (o_fill_addr),
        .o_fill_data          (o_fill_data)
    );

    mhq_ccu mhq_ccu_inst (
        .clk                  (clk),
        .n_rst                (n_rst),
        .i_ccu_en             (ccu_en),
        .i_ccu_addr           (ccu_addr),
        .i_mem_ack            (i_mem_ack),
        .i_mem_data           (i_mem_data),
        .o_ccu_done           (ccu_done),
        .o_ccu_data           (ccu_data),
        .o_mem_req            (o_mem_req),
        .o_mem_addr           (o_mem_addr)
    );

endmodule
